// File: all.f
common/ccc_pkg.sv
hw/ccc/ccc_fsm.sv
hw/ccc/ccc_get_data.sv
hw/ccc/ccc_set_regs.sv
hw/ccc/ccc_top.sv
sim/ccc_assertions.sv
sim/ccc_tb.sv

// File: common/ccc_pkg.sv
// Command codes, field widths and shared struct types for the I3C target CCC handler
`default_nettype none

package ccc_pkg;

  localparam int unsigned AddrW = 7;
  localparam int unsigned LenW = 16;
  localparam int unsigned PidW = 48;

  // Bit 7 set marks a direct command
  typedef logic [7:0] ccc_code_t;

  // Broadcast codes
  localparam ccc_code_t CccBcastEnec = 8'h00;
  localparam ccc_code_t CccBcastDisec = 8'h01;
  localparam ccc_code_t CccBcastRstdaa = 8'h06;
  localparam ccc_code_t CccBcastSetmwl = 8'h09;
  localparam ccc_code_t CccBcastSetmrl = 8'h0A;

  // Direct codes
  localparam ccc_code_t CccDirectEnec = 8'h80;
  localparam ccc_code_t CccDirectDisec = 8'h81;
  localparam ccc_code_t CccDirectSetmwl = 8'h89;
  localparam ccc_code_t CccDirectSetmrl = 8'h8A;
  localparam ccc_code_t CccDirectGetmwl = 8'h8B;
  localparam ccc_code_t CccDirectGetmrl = 8'h8C;
  localparam ccc_code_t CccDirectGetpid = 8'h8D;
  localparam ccc_code_t CccDirectGetbcr = 8'h8E;
  localparam ccc_code_t CccDirectGetdcr = 8'h8F;
  localparam ccc_code_t CccDirectGetstatus = 8'h90;

  localparam logic [AddrW-1:0] RsvdAddr = 7'h7E;

  // Bus monitor and bus engine events
  typedef struct packed {
    logic       start_det;
    logic       rstart_det;
    logic       stop_det;
    logic       rx_done;
    logic       tx_done;
    logic [7:0] rx_data;
  } bus_evt_t;

  // Requests to the bus engine, held until the matching done strobe
  typedef struct packed {
    logic       rx_req_bit;
    logic       rx_req_byte;
    logic       tx_req_bit;
    logic       tx_req_byte;
    logic [7:0] tx_value;
    logic       sel_od_pp;
  } bus_req_t;

  typedef struct packed {
    logic [AddrW-1:0] sta_addr;
    logic             sta_valid;
    logic [AddrW-1:0] dyn_addr;
    logic             dyn_valid;
  } tgt_addr_t;

  typedef struct packed {
    logic [7:0]      bcr;
    logic [7:0]      dcr;
    logic [PidW-1:0] pid;
    logic [LenW-1:0] get_mwl;
    logic [LenW-1:0] get_mrl;
    logic [15:0]     status;
  } dev_info_t;

  // ENEC/DISEC bits 0, 1 and 3
  typedef struct packed {
    logic ibi;
    logic crr;
    logic hj;
  } ec_t;

  typedef struct packed {
    logic       rx_byte_done;
    logic [2:0] data_idx;
    logic [7:0] rx_byte;
    logic       get_start;
    logic       get_next;
    logic       tbit_bcast_done;
  } fsm_ctl_t;

endpackage

`default_nettype wire

// File: hw/ccc/ccc_fsm.sv
// CCC protocol FSM: walks the transfer after the command code, matches addresses, drives bus requests
`default_nettype none

module ccc_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  ccc_pkg::ccc_code_t  ccc_i,
  input  logic                ccc_valid_i,
  input  ccc_pkg::bus_evt_t   bus_i,
  input  ccc_pkg::tgt_addr_t  tgt_addr_i,
  input  logic [7:0]          get_byte_i,
  input  logic                get_last_i,
  output ccc_pkg::bus_req_t   bus_req_o,
  output ccc_pkg::fsm_ctl_t   ctl_o,
  output ccc_pkg::ccc_code_t  code_o,
  output logic                done_o,
  output logic                next_ccc_o
);

  typedef enum logic [3:0] {
    Idle,
    WaitCcc,
    RxTbit,
    RxData,
    RxDataTbit,
    RxAddr,
    TxAck,
    TxData,
    TxDataTbit,
    WaitBusCond,
    NextCcc,
    DoneCcc
  } state_e;

  state_e state_q, state_d;

  ccc_pkg::ccc_code_t       code_q;
  logic [ccc_pkg::AddrW-1:0] addr_q;
  logic                     rnw_q;
  logic [7:0]               rx_byte_q;
  logic [2:0]               idx_q;
  logic                     next_ccc_q;

  logic sr_det;
  logic is_get;
  logic supported;
  logic addr_match;
  logic is_rsvd;
  logic addr_ack;
  logic rx_byte_done;

  // A Start without a Stop before it is treated like a Repeated Start
  assign sr_det = bus_i.rstart_det | bus_i.start_det;

  assign is_get = code_q inside {
    ccc_pkg::CccDirectGetmwl, ccc_pkg::CccDirectGetmrl, ccc_pkg::CccDirectGetpid,
    ccc_pkg::CccDirectGetbcr, ccc_pkg::CccDirectGetdcr, ccc_pkg::CccDirectGetstatus
  };
  assign supported = is_get | (code_q inside {
    ccc_pkg::CccDirectEnec, ccc_pkg::CccDirectDisec,
    ccc_pkg::CccDirectSetmwl, ccc_pkg::CccDirectSetmrl
  });

  assign addr_match = (tgt_addr_i.dyn_valid && addr_q == tgt_addr_i.dyn_addr) ||
                      (tgt_addr_i.sta_valid && addr_q == tgt_addr_i.sta_addr);
  assign is_rsvd = (addr_q == ccc_pkg::RsvdAddr);
  assign addr_ack = (addr_match && supported) || is_rsvd;

  assign rx_byte_done = (state_q == RxDataTbit) && bus_i.rx_done;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle:        state_d = WaitCcc;
      WaitCcc:     if (ccc_valid_i) state_d = RxTbit;
      RxTbit: begin
        // Direct commands idle until the Sr that leads to the address
        if (bus_i.rx_done) state_d = code_q[7] ? WaitBusCond : RxData;
      end
      RxData: begin
        if (sr_det) state_d = RxAddr;
        else if (bus_i.rx_done) state_d = RxDataTbit;
      end
      RxDataTbit:  if (bus_i.rx_done) state_d = RxData;
      RxAddr:      if (bus_i.rx_done) state_d = TxAck;
      TxAck: begin
        if (bus_i.tx_done) begin
          if (is_rsvd) state_d = NextCcc;
          else if (addr_ack && rnw_q && is_get) state_d = TxData;
          else if (addr_ack && !rnw_q && !is_get) state_d = RxData;
          else state_d = WaitBusCond;
        end
      end
      TxData: begin
        if (sr_det) state_d = RxAddr;
        else if (bus_i.tx_done) state_d = TxDataTbit;
      end
      TxDataTbit:  if (bus_i.tx_done) state_d = get_last_i ? WaitBusCond : TxData;
      WaitBusCond: if (sr_det) state_d = RxAddr;
      NextCcc:     state_d = WaitCcc;
      DoneCcc:     state_d = WaitCcc;
      default:     state_d = Idle;
    endcase
  end

  always_comb begin
    bus_req_o = '0;
    unique case (state_q)
      RxTbit, RxDataTbit: bus_req_o.rx_req_bit = 1'b1;
      RxData: bus_req_o.rx_req_byte = !sr_det;
      RxAddr: bus_req_o.rx_req_byte = 1'b1;
      TxAck: begin
        // Open drain, low means ACK
        bus_req_o.tx_req_bit = 1'b1;
        bus_req_o.tx_value = {7'h00, ~addr_ack};
      end
      TxData: begin
        bus_req_o.tx_req_byte = 1'b1;
        bus_req_o.tx_value = get_byte_i;
        bus_req_o.sel_od_pp = 1'b1;
      end
      TxDataTbit: begin
        // T-bit high while more bytes follow
        bus_req_o.tx_req_bit = 1'b1;
        bus_req_o.tx_value = {7'h00, ~get_last_i};
        bus_req_o.sel_od_pp = 1'b1;
      end
      default: bus_req_o = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      next_ccc_q <= 1'b0;
      code_q <= '0;
      idx_q <= '0;
    end else begin
      // Stop ends the CCC from any state
      state_q <= bus_i.stop_det ? DoneCcc : state_d;
      next_ccc_q <= (state_q == NextCcc);
      if (ccc_valid_i) code_q <= ccc_i;
      if (ccc_valid_i || (state_q == RxAddr && bus_i.rx_done)) begin
        idx_q <= '0;
      end else if (rx_byte_done && idx_q != '1) begin
        idx_q <= idx_q + 3'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == RxAddr && bus_i.rx_done) begin
      addr_q <= bus_i.rx_data[7:1];
      rnw_q <= bus_i.rx_data[0];
    end
    if (state_q == RxData && bus_i.rx_done) rx_byte_q <= bus_i.rx_data;
  end

  assign ctl_o.rx_byte_done = rx_byte_done;
  assign ctl_o.data_idx = idx_q;
  assign ctl_o.rx_byte = rx_byte_q;
  assign ctl_o.get_start = (state_q == TxAck) && bus_i.tx_done && addr_ack && rnw_q && is_get;
  assign ctl_o.get_next = (state_q == TxDataTbit) && bus_i.tx_done;
  assign ctl_o.tbit_bcast_done = (state_q == RxTbit) && bus_i.rx_done;

  assign code_o = code_q;
  assign done_o = (state_q == DoneCcc);
  assign next_ccc_o = next_ccc_q;

endmodule

`default_nettype wire

// File: hw/ccc/ccc_get_data.sv
// Byte counter and byte selection for the direct GET responses of the CCC handler
`default_nettype none

module ccc_get_data (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  ccc_pkg::ccc_code_t  code_i,
  input  ccc_pkg::dev_info_t  dev_info_i,
  input  ccc_pkg::fsm_ctl_t   ctl_i,
  output logic [7:0]          get_byte_o,
  output logic                get_last_o
);

  logic [2:0]               cnt_q;
  logic [2:0]               cnt_init;
  logic [ccc_pkg::PidW-1:0] payload;
  logic [ccc_pkg::PidW-1:0] shifted;

  // Right aligned payload, counter N selects byte N-1 so MSB goes first
  always_comb begin
    cnt_init = '0;
    payload = '0;
    case (code_i)
      ccc_pkg::CccDirectGetbcr: begin
        cnt_init = 3'd1;
        payload[7:0] = dev_info_i.bcr;
      end
      ccc_pkg::CccDirectGetdcr: begin
        cnt_init = 3'd1;
        payload[7:0] = dev_info_i.dcr;
      end
      ccc_pkg::CccDirectGetstatus: begin
        cnt_init = 3'd2;
        payload[15:0] = dev_info_i.status;
      end
      ccc_pkg::CccDirectGetmwl: begin
        cnt_init = 3'd2;
        payload[15:0] = dev_info_i.get_mwl;
      end
      ccc_pkg::CccDirectGetmrl: begin
        // Third byte is the max IBI payload, fixed at 255
        cnt_init = 3'd3;
        payload[23:0] = {dev_info_i.get_mrl, 8'hFF};
      end
      ccc_pkg::CccDirectGetpid: begin
        cnt_init = 3'd6;
        payload = dev_info_i.pid;
      end
      default: cnt_init = '0;
    endcase
  end

  assign shifted = payload >> {cnt_q - 3'd1, 3'b000};
  assign get_byte_o = shifted[7:0];
  assign get_last_o = (cnt_q <= 3'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (ctl_i.get_start) begin
      cnt_q <= cnt_init;
    end else if (ctl_i.get_next && cnt_q != '0) begin
      cnt_q <= cnt_q - 3'd1;
    end
  end

endmodule

`default_nettype wire

// File: hw/ccc/ccc_set_regs.sv
// Setter register block: captures ENEC, DISEC, SETMWL, SETMRL data and emits RSTDAA and set pulses
`default_nettype none

module ccc_set_regs (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  ccc_pkg::ccc_code_t         code_i,
  input  ccc_pkg::fsm_ctl_t          ctl_i,
  output ccc_pkg::ec_t               enec_o,
  output ccc_pkg::ec_t               disec_o,
  output logic                       rstdaa_o,
  output logic                       set_mwl_o,
  output logic                       set_mrl_o,
  output logic [ccc_pkg::LenW-1:0]   mwl_o,
  output logic [ccc_pkg::LenW-1:0]   mrl_o
);

  logic         is_enec;
  logic         is_disec;
  logic         is_mwl;
  logic         is_mrl;
  logic         first_byte;
  logic         second_byte;
  ccc_pkg::ec_t ec_rx;

  // Broadcast and direct forms behave the same here
  assign is_enec = code_i inside {ccc_pkg::CccBcastEnec, ccc_pkg::CccDirectEnec};
  assign is_disec = code_i inside {ccc_pkg::CccBcastDisec, ccc_pkg::CccDirectDisec};
  assign is_mwl = code_i inside {ccc_pkg::CccBcastSetmwl, ccc_pkg::CccDirectSetmwl};
  assign is_mrl = code_i inside {ccc_pkg::CccBcastSetmrl, ccc_pkg::CccDirectSetmrl};

  assign first_byte = ctl_i.rx_byte_done && (ctl_i.data_idx == 3'd0);
  assign second_byte = ctl_i.rx_byte_done && (ctl_i.data_idx == 3'd1);

  assign ec_rx = '{ibi: ctl_i.rx_byte[0], crr: ctl_i.rx_byte[1], hj: ctl_i.rx_byte[3]};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enec_o <= '0;
      disec_o <= '0;
      rstdaa_o <= 1'b0;
      set_mwl_o <= 1'b0;
      set_mrl_o <= 1'b0;
      mwl_o <= '0;
      mrl_o <= '0;
    end else begin
      // One-cycle pulses
      rstdaa_o <= ctl_i.tbit_bcast_done && (code_i == ccc_pkg::CccBcastRstdaa);
      set_mwl_o <= second_byte && is_mwl;
      set_mrl_o <= second_byte && is_mrl;

      if (first_byte && is_enec) enec_o <= ec_rx;
      if (first_byte && is_disec) disec_o <= ec_rx;

      // Lengths arrive high byte first
      if (first_byte && is_mwl) mwl_o[ccc_pkg::LenW-1:8] <= ctl_i.rx_byte;
      if (second_byte && is_mwl) mwl_o[7:0] <= ctl_i.rx_byte;
      if (first_byte && is_mrl) mrl_o[ccc_pkg::LenW-1:8] <= ctl_i.rx_byte;
      if (second_byte && is_mrl) mrl_o[7:0] <= ctl_i.rx_byte;
    end
  end

endmodule

`default_nettype wire

// File: hw/ccc/ccc_top.sv
// Top level of the CCC handler, connects the FSM with the GET data path and setter registers
`default_nettype none

module ccc_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  ccc_pkg::ccc_code_t         ccc_i,
  input  logic                       ccc_valid_i,
  input  ccc_pkg::bus_evt_t          bus_i,
  input  ccc_pkg::tgt_addr_t         tgt_addr_i,
  input  ccc_pkg::dev_info_t         dev_info_i,
  output ccc_pkg::bus_req_t          bus_req_o,
  output logic                       done_o,
  output logic                       next_ccc_o,
  output ccc_pkg::ec_t               enec_o,
  output ccc_pkg::ec_t               disec_o,
  output logic                       rstdaa_o,
  output logic                       set_mwl_o,
  output logic                       set_mrl_o,
  output logic [ccc_pkg::LenW-1:0]   mwl_o,
  output logic [ccc_pkg::LenW-1:0]   mrl_o
);

  ccc_pkg::fsm_ctl_t  ctl;
  ccc_pkg::ccc_code_t code;
  logic [7:0]         get_byte;
  logic               get_last;

  ccc_fsm ccc_fsm_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ccc_i       (ccc_i),
    .ccc_valid_i (ccc_valid_i),
    .bus_i       (bus_i),
    .tgt_addr_i  (tgt_addr_i),
    .get_byte_i  (get_byte),
    .get_last_i  (get_last),
    .bus_req_o   (bus_req_o),
    .ctl_o       (ctl),
    .code_o      (code),
    .done_o      (done_o),
    .next_ccc_o  (next_ccc_o)
  );

  ccc_get_data ccc_get_data_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .code_i     (code),
    .dev_info_i (dev_info_i),
    .ctl_i      (ctl),
    .get_byte_o (get_byte),
    .get_last_o (get_last)
  );

  ccc_set_regs ccc_set_regs_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .code_i    (code),
    .ctl_i     (ctl),
    .enec_o    (enec_o),
    .disec_o   (disec_o),
    .rstdaa_o  (rstdaa_o),
    .set_mwl_o (set_mwl_o),
    .set_mrl_o (set_mrl_o),
    .mwl_o     (mwl_o),
    .mrl_o     (mrl_o)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the CCC handler testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal --top-module ccc_tb -f all.f -o ccc_sim

./obj_dir/ccc_sim > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
exit 0

// File: sim/ccc_assertions.sv
// Protocol assertions for the CCC handler, bound to the top level from the testbench
`default_nettype none

module ccc_assertions (
  input logic                     clk_i,
  input logic                     rst_ni,
  input ccc_pkg::bus_req_t        bus_req_o,
  input logic                     done_o,
  input logic                     next_ccc_o,
  input ccc_pkg::ec_t             enec_o,
  input ccc_pkg::ec_t             disec_o,
  input logic                     rstdaa_o,
  input logic                     set_mwl_o,
  input logic                     set_mrl_o,
  input logic [ccc_pkg::LenW-1:0] mwl_o,
  input logic [ccc_pkg::LenW-1:0] mrl_o
);

  // Receive and transmit requests exclude each other
  no_rx_tx_overlap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((bus_req_o.rx_req_bit || bus_req_o.rx_req_byte) &&
      (bus_req_o.tx_req_bit || bus_req_o.tx_req_byte)))
    else $error("Bus requests rx and tx at the same time");

  done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o)
    else $error("done_o held longer than one cycle");

  set_mwl_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    set_mwl_o |=> !set_mwl_o)
    else $error("set_mwl_o held longer than one cycle");

  set_mrl_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    set_mrl_o |=> !set_mrl_o)
    else $error("set_mrl_o held longer than one cycle");

  rstdaa_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rstdaa_o |=> !rstdaa_o)
    else $error("rstdaa_o held longer than one cycle");

  // Everything quiet while reset is held
  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (bus_req_o == '0 && !done_o && !next_ccc_o && !rstdaa_o &&
                 !set_mwl_o && !set_mrl_o && enec_o == '0 && disec_o == '0 &&
                 mwl_o == '0 && mrl_o == '0))
    else $error("Outputs not low during reset");

endmodule

`default_nettype wire

// File: sim/ccc_tb.sv
// Testbench for the CCC handler: clock, reset, bus-engine model, CCC sequences and value checks
`default_nettype none

module ccc_tb;

  localparam int unsigned MaxCycles = 3000;
  localparam logic [6:0] DynAddr = 7'h2A;

  logic clk_i;
  logic rst_ni;
  ccc_pkg::ccc_code_t ccc;
  logic ccc_valid;
  ccc_pkg::bus_evt_t bus_evt;
  ccc_pkg::tgt_addr_t tgt_addr;
  ccc_pkg::dev_info_t dev_info;
  ccc_pkg::bus_req_t bus_req;
  logic done;
  logic next_ccc;
  ccc_pkg::ec_t enec;
  ccc_pkg::ec_t disec;
  logic rstdaa;
  logic set_mwl;
  logic set_mrl;
  logic [ccc_pkg::LenW-1:0] mwl;
  logic [ccc_pkg::LenW-1:0] mrl;

  int unsigned cycles;
  int unsigned checks;
  int unsigned errors;
  int unsigned mwl_pulses;
  int unsigned mrl_pulses;
  int unsigned rstdaa_pulses;

  ccc_top ccc_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ccc_i       (ccc),
    .ccc_valid_i (ccc_valid),
    .bus_i       (bus_evt),
    .tgt_addr_i  (tgt_addr),
    .dev_info_i  (dev_info),
    .bus_req_o   (bus_req),
    .done_o      (done),
    .next_ccc_o  (next_ccc),
    .enec_o      (enec),
    .disec_o     (disec),
    .rstdaa_o    (rstdaa),
    .set_mwl_o   (set_mwl),
    .set_mrl_o   (set_mrl),
    .mwl_o       (mwl),
    .mrl_o       (mrl)
  );

  bind ccc_top ccc_assertions ccc_assertions_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bus_req_o  (bus_req_o),
    .done_o     (done_o),
    .next_ccc_o (next_ccc_o),
    .enec_o     (enec_o),
    .disec_o    (disec_o),
    .rstdaa_o   (rstdaa_o),
    .set_mwl_o  (set_mwl_o),
    .set_mrl_o  (set_mrl_o),
    .mwl_o      (mwl_o),
    .mrl_o      (mrl_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == MaxCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", MaxCycles);
      $display("Done: errors found");
      $finish;
    end
  end

  // Pulse counters, sampled away from the active edge
  always @(negedge clk_i) begin
    if (set_mwl) mwl_pulses <= mwl_pulses + 1;
    if (set_mrl) mrl_pulses <= mrl_pulses + 1;
    if (rstdaa) rstdaa_pulses <= rstdaa_pulses + 1;
  end

  task automatic check(input string name, input logic [47:0] exp, input logic [47:0] act);
    checks++;
    assert (exp === act) else begin
      $display("ERR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  // ENEC/DISEC event bits 0, 1 and 3
  function automatic ccc_pkg::ec_t ec_of(input logic [7:0] b);
    ccc_pkg::ec_t ec;
    ec.ibi = b[0];
    ec.crr = b[1];
    ec.hj = b[3];
    return ec;
  endfunction

  // Bus engine answers 1 to 4 cycles after the request
  task automatic bus_delay();
    int unsigned d;
    d = $urandom_range(4, 1);
    repeat (d - 1) @(negedge clk_i);
  endtask

  task automatic recv_byte(input logic [7:0] data);
    while (!bus_req.rx_req_byte) @(negedge clk_i);
    bus_delay();
    bus_evt.rx_data = data;
    bus_evt.rx_done = 1'b1;
    @(negedge clk_i);
    bus_evt.rx_done = 1'b0;
  endtask

  task automatic recv_bit();
    while (!bus_req.rx_req_bit) @(negedge clk_i);
    bus_delay();
    bus_evt.rx_done = 1'b1;
    @(negedge clk_i);
    bus_evt.rx_done = 1'b0;
  endtask

  task automatic send_byte(output logic [7:0] value);
    while (!bus_req.tx_req_byte) @(negedge clk_i);
    bus_delay();
    value = bus_req.tx_value;
    bus_evt.tx_done = 1'b1;
    @(negedge clk_i);
    bus_evt.tx_done = 1'b0;
  endtask

  task automatic send_bit(output logic value);
    while (!bus_req.tx_req_bit) @(negedge clk_i);
    bus_delay();
    value = bus_req.tx_value[0];
    bus_evt.tx_done = 1'b1;
    @(negedge clk_i);
    bus_evt.tx_done = 1'b0;
  endtask

  // Command code from the primary FSM, then its T-bit
  task automatic start_ccc(input ccc_pkg::ccc_code_t code);
    ccc = code;
    ccc_valid = 1'b1;
    @(negedge clk_i);
    ccc_valid = 1'b0;
    recv_bit();
  endtask

  task automatic addr_phase(input logic [6:0] addr, input logic rnw, input logic exp_nack);
    logic ack;
    bus_evt.rstart_det = 1'b1;
    @(negedge clk_i);
    bus_evt.rstart_det = 1'b0;
    recv_byte({addr, rnw});
    send_bit(ack);
    check("bus_req_o.tx_value (ack)", 48'(exp_nack), 48'(ack));
  endtask

  task automatic stop_bus();
    bus_evt.stop_det = 1'b1;
    @(negedge clk_i);
    bus_evt.stop_det = 1'b0;
    check("done_o", 48'(1'b1), 48'(done));
    check("bus_req_o", 48'(0), 48'(bus_req));
    @(negedge clk_i);
    check("done_o", 48'(1'b0), 48'(done));
  endtask

  // MSB first, T-bit high until the last byte
  task automatic read_getter(input ccc_pkg::ccc_code_t code, input logic [47:0] val,
                             input int n);
    logic [7:0] b;
    logic t;
    start_ccc(code);
    addr_phase(DynAddr, 1'b1, 1'b0);
    for (int i = 0; i < n; i++) begin
      send_byte(b);
      check("bus_req_o.tx_value (byte)", 48'(val >> (8 * (n - 1 - i)) & 48'hFF), 48'(b));
      send_bit(t);
      check("bus_req_o.tx_value (T-bit)", 48'(i != n - 1), 48'(t));
    end
    stop_bus();
  endtask

  initial begin
    logic [7:0] b;
    void'($urandom(32'h0702_651d));
    rst_ni = 1'b0;
    ccc = '0;
    ccc_valid = 1'b0;
    bus_evt = '0;
    tgt_addr = '{sta_addr: 7'h15, sta_valid: 1'b1, dyn_addr: DynAddr, dyn_valid: 1'b1};
    dev_info = '{bcr: 8'h26, dcr: 8'hC3, pid: 48'h5A12_3456_789B,
                 get_mwl: 16'h0100, get_mrl: 16'h0203, status: 16'h0000};
    cycles = 0;
    checks = 0;
    errors = 0;
    mwl_pulses = 0;
    mrl_pulses = 0;
    rstdaa_pulses = 0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    start_ccc(ccc_pkg::CccBcastEnec);
    recv_byte(8'h0B);
    recv_bit();
    check("enec_o", 48'(ec_of(8'h0B)), 48'(enec));
    stop_bus();
    start_ccc(ccc_pkg::CccBcastDisec);
    recv_byte(8'h01);
    recv_bit();
    check("disec_o", 48'(ec_of(8'h01)), 48'(disec));
    stop_bus();

    start_ccc(ccc_pkg::CccBcastSetmwl);
    recv_byte(8'h12);
    recv_bit();
    recv_byte(8'h34);
    recv_bit();
    @(negedge clk_i);
    check("set_mwl_o pulses", 48'(1), 48'(mwl_pulses));
    check("mwl_o", 48'h1234, 48'(mwl));
    stop_bus();
    start_ccc(ccc_pkg::CccDirectSetmrl);
    addr_phase(DynAddr, 1'b0, 1'b0);
    recv_byte(8'h56);
    recv_bit();
    recv_byte(8'h78);
    recv_bit();
    @(negedge clk_i);
    check("set_mrl_o pulses", 48'(1), 48'(mrl_pulses));
    check("mrl_o", 48'h5678, 48'(mrl));
    stop_bus();

    read_getter(ccc_pkg::CccDirectGetpid, dev_info.pid, 6);
    read_getter(ccc_pkg::CccDirectGetmrl, 48'({dev_info.get_mrl, 8'hFF}), 3);

    // Unmatched address stays silent until the next bus condition
    start_ccc(ccc_pkg::CccDirectGetmwl);
    addr_phase(7'h33, 1'b1, 1'b1);
    repeat (8) begin
      @(negedge clk_i);
      check("bus_req_o after NACK", 48'(0), 48'(bus_req));
    end
    stop_bus();

    start_ccc(ccc_pkg::CccBcastRstdaa);
    repeat (3) @(negedge clk_i);
    check("rstdaa_o pulses", 48'(1), 48'(rstdaa_pulses));
    stop_bus();
    start_ccc(ccc_pkg::CccDirectGetbcr);
    addr_phase(ccc_pkg::RsvdAddr, 1'b1, 1'b0);
    @(negedge clk_i);
    check("next_ccc_o", 48'(1'b1), 48'(next_ccc));
    @(negedge clk_i);
    check("next_ccc_o", 48'(1'b0), 48'(next_ccc));
    stop_bus();

    // Stop while the T-bit of a GETPID byte is pending
    start_ccc(ccc_pkg::CccDirectGetpid);
    addr_phase(DynAddr, 1'b1, 1'b0);
    send_byte(b);
    check("bus_req_o.tx_value (byte)", 48'(dev_info.pid[47:40]), 48'(b));
    while (!bus_req.tx_req_bit) @(negedge clk_i);
    stop_bus();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
